// ==== Makefile ====
# Verilator build and run of the sprite engine testbench

VERILATOR ?= verilator
TOP       ?= obj_engine_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "RESULT: PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
+incdir+test
verilog/obj_geom_pkg.sv
verilog/obj_fmt_pkg.sv
verilog/obj_table_ram.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buffer.sv
verilog/obj_engine.sv
test/obj_engine_tb.sv

// ==== test/obj_model.svh ====
// Reference model: sprite table copy, graphics memory image, expected line painter
`ifndef OBJ_MODEL_SVH
`define OBJ_MODEL_SVH

// Table as the CPU should see it
logic [DW-1:0] tbl [0:TBL_WORDS-1];

// Expected buffer half for one target line
logic [PXL_W-1:0] exp_line [0:511];

// Byte writes, strobes active low
function automatic void store_word(input int a, input logic [DW-1:0] d, input logic [1:0] s);
    if (!s[1]) tbl[a][15:8] = d[15:8];
    if (!s[0]) tbl[a][7:0] = d[7:0];
endfunction

// Graphics image, hashed from every address bit
function automatic logic [DW-1:0] gfx_word(input logic [ROM_AW-1:0] a);
    logic [31:0]   h;
    logic [DW-1:0] w;
    int            n;
    h = {14'd0, a} * 32'h9E37_79B1;
    h = h ^ (h >> 15) ^ {14'd0, a};
    w = h[31:16];
    // About one pixel in four transparent
    for (n = 0; n < 4; n++) begin
        if (w[4*n+2 +: 2] == 2'b00) w[4*n +: 4] = 4'h0;
    end
    return w;
endfunction

// Paint every visible entry of the table in index order
function automatic void paint_line(input int target);
    logic [DW-1:0]      lw;
    logic [DW-1:0]      xw;
    logic [DW-1:0]      aw;
    logic [DW-1:0]      tw;
    logic [DW-1:0]      g;
    logic [COLOR_W-1:0] c;
    int                 e;
    int                 w;
    int                 k;
    int                 x;
    int                 wid;
    int                 row;
    int                 word_a;
    for (x = 0; x < 512; x++) exp_line[x] = '0;
    for (e = 0; e < OBJ_N; e++) begin
        lw = tbl[4*e + ENT_LINES];
        xw = tbl[4*e + ENT_XPOS];
        aw = tbl[4*e + ENT_ADDR];
        tw = tbl[4*e + ENT_ATTR];
        // End marker, nothing after it
        if (xw[15]) break;
        if (target >= int'(lw[7:0]) && target < int'(lw[15:8])) begin
            row = target - int'(lw[7:0]);
            wid = int'(xw[14:12]) + 1;
            for (w = 0; w < wid; w++) begin
                // Offset sum wraps at 14 bits, bank on top
                word_a = int'(tw[11:8]) * 16384 + (int'(aw[13:0]) + row * wid + w) % 16384;
                g = gfx_word(ROM_AW'(word_a));
                for (k = 0; k < 4; k++) begin
                    c = g[15 - 4*k -: 4];
                    // Later entries overwrite
                    if (c != '0) begin
                        exp_line[(int'(xw[8:0]) + 4*w + k) % 512] = {tw[5:0], tw[7:6], c};
                    end
                end
            end
        end
    end
endfunction

`endif

// ==== test/obj_engine_tb.sv ====
// Sprite engine testbench: clock, reset, video timing, memory responder, random table checks
`timescale 1ns/1ns

module obj_engine_tb
    import obj_geom_pkg::*, obj_fmt_pkg::*;
();

    localparam int OBJ_N = 32;
    localparam int TBL_WORDS = OBJ_N * ENTRY_WORDS;
    localparam logic [XW-1:0] START_POS = 9'd8;
    localparam int VIS_PX = 320;
    localparam int BLANK_PX = 200;
    localparam int N_FRAMES = 24;
    localparam int IDLE_TIMEOUT = 2000;

    logic              clk;
    logic              rst_n;
    logic              cpu_cs;
    logic [CPU_AW-1:0] cpu_addr;
    logic [DW-1:0]     cpu_dout;
    logic [1:0]        dsn;
    logic [DW-1:0]     cpu_din;
    logic              rom_cs;
    logic [ROM_AW-1:0] rom_addr;
    logic              rom_ok = 1'b0;
    logic [DW-1:0]     rom_data = '0;
    logic              pxl_cen;
    logic              hstart;
    logic              lhbl;
    logic [XW-1:0]     vrender;
    logic [PXL_W-1:0]  pxl;

    int errors = 0;
    int rom_errors = 0;
    int checks = 0;
    // Responder state
    int pending = 0;
    int delay = 0;
    logic [ROM_AW-1:0] req_addr;

    // Expected readout for the current line
    logic [PXL_W-1:0] shown [0:511];

    `include "obj_model.svh"

    obj_engine #(.OBJ_MAX(OBJ_N), .START_X(START_POS)) i_dut (
        .clk(clk), .rst_n(rst_n),
        .cpu_cs(cpu_cs), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .dsn(dsn),
        .cpu_din(cpu_din),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_ok(rom_ok), .rom_data(rom_data),
        .pxl_cen(pxl_cen), .hstart(hstart), .lhbl(lhbl), .vrender(vrender), .pxl(pxl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Graphics memory, 1 to 6 cycles per request
    always @(negedge clk) begin
        if (!rom_cs) begin
            rom_ok = 1'b0;
            pending = 0;
        end else if (!rom_ok) begin
            if (pending == 0) begin
                pending = 1;
                delay = 1 + int'($urandom % 6);
                req_addr = rom_addr;
            end else if (rom_addr !== req_addr) begin
                rom_errors++;
                $display("[FAIL] t=%0t rom_addr: expected %05h, got %05h",
                         $time, req_addr, rom_addr);
            end
            delay--;
            if (delay == 0) begin
                rom_ok = 1'b1;
                rom_data = gfx_word(rom_addr);
            end
        end
    end

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors + rom_errors);
        if (errors + rom_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic cpu_write(input int a, input logic [DW-1:0] d, input logic [1:0] s);
        @(negedge clk);
        cpu_cs = 1'b1;
        cpu_addr = CPU_AW'(a);
        cpu_dout = d;
        dsn = s;
        store_word(a, d, s);
        @(negedge clk);
        cpu_cs = 1'b0;
        dsn = 2'b11;
    endtask

    // Data one cycle after the address
    task automatic cpu_readback(input int a);
        @(negedge clk);
        cpu_addr = CPU_AW'(a);
        @(negedge clk);
        checks++;
        if (cpu_din !== tbl[a]) begin
            errors++;
            $display("[FAIL] t=%0t cpu_din (word %0d): expected %04h, got %04h",
                     $time, a, tbl[a], cpu_din);
        end
    endtask

    task automatic cpu_random_test();
        int a;
        // Full writes first, every word known
        for (a = 0; a < TBL_WORDS; a++) cpu_write(a, DW'($urandom), 2'b00);
        repeat (400) begin
            a = int'($urandom % TBL_WORDS);
            if ($urandom % 3 == 0) begin
                cpu_readback(a);
            end else begin
                cpu_write(a, DW'($urandom), 2'($urandom));
                cpu_readback(a);
            end
        end
        for (a = 0; a < TBL_WORDS; a++) cpu_readback(a);
    endtask

    // Kind 0 visible, 1 hidden, 2 end marker, 3 empty
    task automatic make_entry(input int e, input int target, input int kind);
        int            top;
        int            bot;
        int            x;
        int            sel;
        logic [DW-1:0] xw;
        top = target - int'($urandom % 16);
        if (top < 0) top = 0;
        bot = target + 1 + int'($urandom % 12);
        if (kind == 1) begin
            sel = int'($urandom % 3);
            case (sel)
                0: begin
                    top = target + 1 + int'($urandom % 8);
                    bot = top + 6;
                end
                // Bottom is exclusive
                1: bot = target;
                default: bot = top;
            endcase
        end else if (kind == 3) begin
            top = 0;
            bot = 0;
        end
        // Mostly crowded near the left edge, some anywhere with wrap
        if ($urandom % 4 == 0) x = int'($urandom % 512);
        else x = int'(START_POS) + int'($urandom % 200);
        xw = {kind == 2, 3'($urandom % 8), 3'b000, 9'(x)};
        cpu_write(4*e + ENT_LINES, {8'(bot), 8'(top)}, 2'b00);
        cpu_write(4*e + ENT_XPOS, xw, 2'b00);
        cpu_write(4*e + ENT_ADDR, DW'($urandom % 16384), 2'b00);
        cpu_write(4*e + ENT_ATTR, DW'($urandom % 4096), 2'b00);
    endtask

    // Sprites first, then maybe an end marker followed by sprites never drawn
    task automatic build_table(input int target, input int n_spr);
        int   e;
        logic mark;
        mark = (n_spr == 0) || ($urandom % 4 != 0);
        for (e = 0; e < OBJ_N; e++) begin
            if (e < n_spr) begin
                if ($urandom % 5 == 0) make_entry(e, target, 1);
                else make_entry(e, target, 0);
            end else if (e == n_spr && mark) begin
                make_entry(e, target, 2);
            end else if (mark) begin
                make_entry(e, target, 0);
            end else begin
                make_entry(e, target, 3);
            end
        end
    endtask

    // One video line; readout shows what the previous line drew
    task automatic run_line(input int v, input logic chk);
        int i;
        int a;
        for (i = 0; i < 512; i++) shown[i] = exp_line[i];
        paint_line(v + 1);
        for (i = 0; i < BLANK_PX; i++) begin
            @(negedge clk);
            hstart = (i == 0);
            vrender = XW'(v);
            lhbl = 1'b0;
            pxl_cen = 1'b1;
            @(negedge clk);
            hstart = 1'b0;
            pxl_cen = 1'b0;
            checks++;
            if (pxl !== '0) begin
                errors++;
                $display("[FAIL] t=%0t pxl (blank): expected 000, got %03h", $time, pxl);
            end
        end
        for (i = 0; i < VIS_PX; i++) begin
            @(negedge clk);
            lhbl = 1'b1;
            pxl_cen = 1'b1;
            @(negedge clk);
            pxl_cen = 1'b0;
            a = (int'(START_POS) + i) % 512;
            if (chk) begin
                checks++;
                if (pxl !== shown[a]) begin
                    errors++;
                    $display("[FAIL] t=%0t pxl (x %0d): expected %03h, got %03h",
                             $time, a, shown[a], pxl);
                end
            end
        end
        @(negedge clk);
        lhbl = 1'b0;
    endtask

    // Memory quiet for 8 cycles means the drawer is done
    task automatic wait_mem_idle();
        int n;
        int quiet;
        quiet = 0;
        for (n = 0; n < IDLE_TIMEOUT; n++) begin
            @(negedge clk);
            if (rom_cs) quiet = 0;
            else quiet++;
            if (quiet >= 8) return;
        end
        errors++;
        $display("Timeout: graphics memory requests did not stop within %0d cycles",
                 IDLE_TIMEOUT);
        finish_run();
    endtask

    initial begin
        int f;
        int v;
        int n;
        void'($urandom(24));
        rst_n = 1'b0;
        cpu_cs = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn = 2'b11;
        pxl_cen = 1'b0;
        hstart = 1'b0;
        lhbl = 1'b0;
        vrender = '0;
        repeat (16) @(negedge clk);
        checks += 2;
        if (rom_cs !== 1'b0) begin
            errors++;
            $display("[FAIL] t=%0t rom_cs: expected 0, got %b", $time, rom_cs);
        end
        if (pxl !== '0) begin
            errors++;
            $display("[FAIL] t=%0t pxl: expected 000, got %03h", $time, pxl);
        end
        rst_n = 1'b1;
        cpu_random_test();
        // Empty table, two lines to clear both buffer halves
        build_table(40, 0);
        run_line(20, 1'b0);
        run_line(21, 1'b0);
        v = 21;
        for (f = 0; f < N_FRAMES; f++) begin
            wait_mem_idle();
            v = 16 + int'($urandom % 180);
            // Every fourth line without sprites, erase check
            if (f % 4 == 3) n = 0;
            else n = 1 + int'($urandom % 7);
            build_table(v + 1, n);
            run_line(v, 1'b1);
        end
        wait_mem_idle();
        build_table(v + 1, 0);
        run_line(v, 1'b1);
        run_line(v + 1, 1'b1);
        finish_run();
    end

endmodule

// ==== verilog/obj_draw.sv ====
// Sprite drawer: graphics memory fetch per word, opaque pixel writes into the line buffer
`timescale 1ns/1ns

module obj_draw import obj_geom_pkg::*, obj_fmt_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // Draw command
    input  logic              dr_start,
    output logic              dr_busy,
    input  logic [XW-1:0]     dr_xpos,
    input  logic [OFS_W-1:0]  dr_offset,
    input  logic [BANK_W-1:0] dr_bank,
    input  logic [WID_W-1:0]  dr_width,
    input  logic [LINE_W-1:0] dr_row,
    input  logic [PRIO_W-1:0] dr_prio,
    input  logic [PAL_W-1:0]  dr_pal,
    // Graphics memory
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ok,
    input  logic [DW-1:0]     rom_data,
    // Line buffer write
    output logic              buf_we,
    output logic [XW-1:0]     buf_addr,
    output logic [PXL_W-1:0]  buf_data
);

    localparam int KW = $clog2(PIX_PER_WORD);

    typedef enum logic [1:0] {D_IDLE, D_FETCH, D_PIX} state_t;

    state_t              st;
    logic [KW-1:0]       k;
    logic [WID_W-1:0]    wcnt;
    logic [WID_W-1:0]    width_r;
    logic [BANK_W-1:0]   bank_r;
    logic [OFS_W-1:0]    ofs_r;
    logic [PAL_W-1:0]    pal_r;
    logic [PRIO_W-1:0]   prio_r;
    logic [XW-1:0]       cur_x;
    logic [DW-1:0]       pix_w;
    logic [COLOR_W-1:0]  color;
    logic                word_end;
    logic                got_word;

    // Current pixel sits in the top nibble
    assign color = pix_w[DW-1 -: COLOR_W];
    assign word_end = (k == KW'(PIX_PER_WORD - 1));
    assign got_word = (st == D_FETCH) && rom_cs && rom_ok;

    // Address stays put while rom_cs is up
    assign rom_addr = {bank_r, ofs_r};

    // Colour 0 is transparent, nothing written
    assign buf_we = (st == D_PIX) && (color != '0);
    assign buf_addr = cur_x;
    assign buf_data = {pal_r, prio_r, color};

    // Control FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st <= D_IDLE;
            dr_busy <= 1'b0;
            rom_cs <= 1'b0;
            k <= '0;
            wcnt <= '0;
        end else begin
            case (st)
                D_IDLE: begin
                    if (dr_start) begin
                        st <= D_FETCH;
                        dr_busy <= 1'b1;
                        rom_cs <= 1'b1;
                        wcnt <= '0;
                    end
                end
                D_FETCH: begin
                    // Wait as long as memory needs
                    if (got_word) begin
                        rom_cs <= 1'b0;
                        k <= '0;
                        st <= D_PIX;
                    end
                end
                D_PIX: begin
                    k <= k + 1'd1;
                    if (word_end) begin
                        if (wcnt == width_r) begin
                            // Busy drops after the last write
                            st <= D_IDLE;
                            dr_busy <= 1'b0;
                        end else begin
                            // rom_cs was low for the four write cycles
                            wcnt <= wcnt + 1'd1;
                            rom_cs <= 1'b1;
                            st <= D_FETCH;
                        end
                    end
                end
                default: st <= D_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        case (st)
            D_IDLE: begin
                if (dr_start) begin
                    bank_r <= dr_bank;
                    // Row start, offset plus row times words per row, 14-bit wrap
                    ofs_r <= dr_offset + OFS_W'(dr_row) * (OFS_W'(dr_width) + 1'd1);
                    width_r <= dr_width;
                    pal_r <= dr_pal;
                    prio_r <= dr_prio;
                    cur_x <= dr_xpos;
                end
            end
            D_FETCH: begin
                if (got_word) pix_w <= rom_data;
            end
            D_PIX: begin
                // x wraps at 512 by width
                cur_x <= cur_x + 1'd1;
                pix_w <= pix_w << COLOR_W;
                if (word_end && wcnt != width_r) ofs_r <= ofs_r + 1'd1;
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/obj_engine.sv ====
// Sprite engine top: table RAM, scanner, drawer and line buffer
`timescale 1ns/1ns

module obj_engine import obj_geom_pkg::*, obj_fmt_pkg::*; #(
    parameter int OBJ_MAX = 128,
    parameter logic [XW-1:0] START_X = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    // CPU port
    input  logic              cpu_cs,
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [DW-1:0]     cpu_dout,
    input  logic [1:0]        dsn,
    output logic [DW-1:0]     cpu_din,
    // Graphics memory
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ok,
    input  logic [DW-1:0]     rom_data,
    // Video timing
    input  logic              pxl_cen,
    input  logic              hstart,
    input  logic              lhbl,
    input  logic [XW-1:0]     vrender,
    output logic [PXL_W-1:0]  pxl
);

    localparam int TAW = $clog2(OBJ_MAX * ENTRY_WORDS);

    // Scan port
    logic [TAW-1:0]    tbl_addr;
    logic [DW-1:0]     tbl_dout;

    // Draw command
    logic              dr_start;
    logic              dr_busy;
    logic [XW-1:0]     dr_xpos;
    logic [OFS_W-1:0]  dr_offset;
    logic [BANK_W-1:0] dr_bank;
    logic [WID_W-1:0]  dr_width;
    logic [LINE_W-1:0] dr_row;
    logic [PRIO_W-1:0] dr_prio;
    logic [PAL_W-1:0]  dr_pal;

    // Buffer writes
    logic              buf_we;
    logic [XW-1:0]     buf_addr;
    logic [PXL_W-1:0]  buf_data;

    obj_table_ram #(.OBJ_MAX(OBJ_MAX)) u_ram (
        .clk(clk), .cpu_cs(cpu_cs), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .dsn(dsn), .cpu_din(cpu_din), .tbl_addr(tbl_addr), .tbl_dout(tbl_dout)
    );

    obj_scan #(.OBJ_MAX(OBJ_MAX)) u_scan (
        .clk(clk), .rst_n(rst_n), .hstart(hstart), .vrender(vrender),
        .tbl_addr(tbl_addr), .tbl_dout(tbl_dout),
        .dr_start(dr_start), .dr_busy(dr_busy), .dr_xpos(dr_xpos),
        .dr_offset(dr_offset), .dr_bank(dr_bank), .dr_width(dr_width),
        .dr_row(dr_row), .dr_prio(dr_prio), .dr_pal(dr_pal)
    );

    obj_draw u_draw (
        .clk(clk), .rst_n(rst_n),
        .dr_start(dr_start), .dr_busy(dr_busy), .dr_xpos(dr_xpos),
        .dr_offset(dr_offset), .dr_bank(dr_bank), .dr_width(dr_width),
        .dr_row(dr_row), .dr_prio(dr_prio), .dr_pal(dr_pal),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_ok(rom_ok), .rom_data(rom_data),
        .buf_we(buf_we), .buf_addr(buf_addr), .buf_data(buf_data)
    );

    // Readout start position comes from the top
    obj_line_buffer #(.START_X(START_X)) u_line (
        .clk(clk), .rst_n(rst_n), .hstart(hstart), .lhbl(lhbl), .pxl_cen(pxl_cen),
        .buf_we(buf_we), .buf_addr(buf_addr), .buf_data(buf_data), .pxl(pxl)
    );

endmodule

// ==== verilog/obj_fmt_pkg.sv ====
// Sprite format package: table entry word indices and field positions, pixel word layout
package obj_fmt_pkg;

    // Word index of each field inside one entry
    localparam int ENT_LINES = 0;
    localparam int ENT_XPOS = 1;
    localparam int ENT_ADDR = 2;
    localparam int ENT_ATTR = 3;

    // Lines word, top in the low byte, bottom (exclusive) in the high byte
    localparam int LINE_W = 8;

    // Xpos word fields
    // x position sits in the low bits, XW wide
    localparam int WID_LSB = 12;
    localparam int WID_W = 3;
    localparam int XPOS_END = 15;

    // Attribute word fields
    localparam int PAL_LSB = 0;
    localparam int PRIO_LSB = 6;
    localparam int BANK_LSB = 8;

    // Pixel layout
    localparam int COLOR_W = 4;
    localparam int PAL_W = 6;
    localparam int PRIO_W = 2;

    // Graphics word, four nibbles, leftmost pixel in the top nibble
    localparam int PIX_PER_WORD = 4;

endpackage

// ==== verilog/obj_geom_pkg.sv ====
// Sprite engine geometry package: data, address and position widths, pixel width, entry size
package obj_geom_pkg;

    // CPU and table data word
    localparam int DW = 16;

    // CPU word address into the sprite table
    localparam int CPU_AW = 10;

    // Horizontal and vertical position, 512 positions per line
    localparam int XW = 9;

    // Graphics memory word address, bank on top of offset
    localparam int ROM_AW = 18;
    localparam int BANK_W = 4;
    localparam int OFS_W = ROM_AW - BANK_W;

    // Line buffer word
    localparam int PXL_W = 12;

    // Table words per sprite entry
    localparam int ENTRY_WORDS = 4;

endpackage

// ==== verilog/obj_line_buffer.sv ====
// Ping-pong line buffer: drawer write half, pixel readout half with erase on read
`timescale 1ns/1ns

module obj_line_buffer import obj_geom_pkg::*; #(
    parameter logic [XW-1:0] START_X = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             hstart,
    input  logic             lhbl,
    input  logic             pxl_cen,
    // Drawer side
    input  logic             buf_we,
    input  logic [XW-1:0]    buf_addr,
    input  logic [PXL_W-1:0] buf_data,
    // Video side
    output logic [PXL_W-1:0] pxl
);

    localparam int HALF = 1 << XW;

    // Both halves in one array, top address bit picks the half
    logic [PXL_W-1:0] mem [0:2*HALF-1];

    logic          wr_half;
    logic [XW-1:0] rd_cnt;
    logic [XW:0]   wr_a;
    logic [XW:0]   rd_a;
    logic          rd_en;

    // Readout always uses the other half
    assign wr_a = {wr_half, buf_addr};
    assign rd_a = {~wr_half, rd_cnt};
    assign rd_en = lhbl && pxl_cen;

    // Half select and read counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_half <= 1'b0;
            rd_cnt <= START_X;
            pxl <= '0;
        end else begin
            if (hstart) wr_half <= ~wr_half;
            if (!lhbl) begin
                // Blanking, counter reloads and output is black
                rd_cnt <= START_X;
                pxl <= '0;
            end else if (pxl_cen) begin
                rd_cnt <= rd_cnt + 1'd1;
                pxl <= mem[rd_a];
            end
        end
    end

    // Draw writes, later entries overwrite earlier ones
    // the word just read is cleared for the line after next
    always_ff @(posedge clk) begin
        if (buf_we) mem[wr_a] <= buf_data;
        if (rd_en) mem[rd_a] <= '0;
    end

endmodule

// ==== verilog/obj_scan.sv ====
// Sprite table scanner: per-line walk of the entries, visibility test, draw command issue
`timescale 1ns/1ns

module obj_scan import obj_geom_pkg::*, obj_fmt_pkg::*; #(
    parameter int OBJ_MAX = 128,
    localparam int TAW = $clog2(OBJ_MAX * ENTRY_WORDS)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hstart,
    input  logic [XW-1:0]     vrender,
    // Table read port
    output logic [TAW-1:0]    tbl_addr,
    input  logic [DW-1:0]     tbl_dout,
    // Draw command
    output logic              dr_start,
    input  logic              dr_busy,
    output logic [XW-1:0]     dr_xpos,
    output logic [OFS_W-1:0]  dr_offset,
    output logic [BANK_W-1:0] dr_bank,
    output logic [WID_W-1:0]  dr_width,
    output logic [LINE_W-1:0] dr_row,
    output logic [PRIO_W-1:0] dr_prio,
    output logic [PAL_W-1:0]  dr_pal
);

    localparam int IW = $clog2(OBJ_MAX);
    localparam int WW = $clog2(ENTRY_WORDS);
    localparam int SUB_W = WW + 1;

    typedef enum logic [1:0] {S_IDLE, S_READ, S_WAIT} state_t;

    state_t             st;
    logic [IW-1:0]      idx;
    logic [SUB_W-1:0]   sub;
    logic [XW-1:0]      line;
    logic [DW-1:0]      lines_w;
    logic [DW-1:0]      xpos_w;
    logic [DW-1:0]      addr_w;
    logic [LINE_W-1:0]  top;
    logic [LINE_W-1:0]  bot;
    logic [XW-1:0]      row_full;
    logic               visible;
    logic               last_ent;
    logic               ent_done;

    // Word sub of entry idx, sub runs one past the last word for the data return
    assign tbl_addr = {idx, sub[WW-1:0]};

    assign top = lines_w[LINE_W-1:0];
    assign bot = lines_w[2*LINE_W-1:LINE_W];
    assign row_full = line - XW'(top);
    // Bottom line is exclusive
    assign visible = (line >= XW'(top)) && (line < XW'(bot));
    assign last_ent = (idx == IW'(OBJ_MAX - 1));
    // All four words present, attribute word on tbl_dout
    assign ent_done = (st == S_READ) && (sub == SUB_W'(ENTRY_WORDS));

    // Walk FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st <= S_IDLE;
            idx <= '0;
            sub <= '0;
            line <= '0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= 1'b0;
            if (hstart) begin
                // New line, drop whatever was left
                st <= S_READ;
                idx <= '0;
                sub <= '0;
                line <= vrender + 1'd1;
            end else begin
                case (st)
                    S_READ: begin
                        sub <= sub + 1'd1;
                        if (ent_done) begin
                            sub <= '0;
                            if (xpos_w[XPOS_END]) begin
                                // End marker closes the list
                                st <= S_IDLE;
                            end else if (visible) begin
                                st <= S_WAIT;
                            end else if (last_ent) begin
                                st <= S_IDLE;
                            end else begin
                                idx <= idx + 1'd1;
                            end
                        end
                    end
                    S_WAIT: begin
                        // Drawer free, hand over the command
                        if (!dr_busy) begin
                            dr_start <= 1'b1;
                            if (last_ent) begin
                                st <= S_IDLE;
                            end else begin
                                idx <= idx + 1'd1;
                                st <= S_READ;
                            end
                        end
                    end
                    default: st <= S_IDLE;
                endcase
            end
        end
    end

    // Entry words as they come back
    always_ff @(posedge clk) begin
        if (st == S_READ) begin
            if (sub == SUB_W'(ENT_LINES + 1)) lines_w <= tbl_dout;
            if (sub == SUB_W'(ENT_XPOS + 1)) xpos_w <= tbl_dout;
            if (sub == SUB_W'(ENT_ADDR + 1)) addr_w <= tbl_dout;
        end
    end

    // Command fields, held until the pulse
    always_ff @(posedge clk) begin
        if (ent_done && visible) begin
            dr_xpos <= xpos_w[XW-1:0];
            dr_width <= xpos_w[WID_LSB +: WID_W];
            dr_offset <= addr_w[OFS_W-1:0];
            dr_row <= row_full[LINE_W-1:0];
            dr_bank <= tbl_dout[BANK_LSB +: BANK_W];
            dr_prio <= tbl_dout[PRIO_LSB +: PRIO_W];
            dr_pal <= tbl_dout[PAL_LSB +: PAL_W];
        end
    end

endmodule

// ==== verilog/obj_table_ram.sv ====
// Sprite table RAM: CPU read/write port with byte strobes, read-only scan port
`timescale 1ns/1ns

module obj_table_ram import obj_geom_pkg::*; #(
    parameter int OBJ_MAX = 128,
    localparam int TAW = $clog2(OBJ_MAX * ENTRY_WORDS)
) (
    input  logic              clk,
    // CPU port
    input  logic              cpu_cs,
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [DW-1:0]     cpu_dout,
    input  logic [1:0]        dsn,
    output logic [DW-1:0]     cpu_din,
    // Scanner port
    input  logic [TAW-1:0]    tbl_addr,
    output logic [DW-1:0]     tbl_dout
);

    localparam int DEPTH = OBJ_MAX * ENTRY_WORDS;

    // Table storage, no reset
    logic [DW-1:0] mem [0:DEPTH-1];

    // Only the low address bits reach the table
    logic [TAW-1:0] cpu_a;

    assign cpu_a = cpu_addr[TAW-1:0];

    // CPU side
    always_ff @(posedge clk) begin
        // Strobes are active low
        // upper byte on dsn[1]
        if (cpu_cs && !dsn[1]) begin
            mem[cpu_a][DW-1 -: 8] <= cpu_dout[DW-1 -: 8];
        end
        // Lower byte on dsn[0]
        if (cpu_cs && !dsn[0]) begin
            mem[cpu_a][7:0] <= cpu_dout[7:0];
        end
        // Readback one cycle after the address
        cpu_din <= mem[cpu_a];
    end

    // Scanner side
    // registered read, data on the next cycle
    always_ff @(posedge clk) begin
        tbl_dout <= mem[tbl_addr];
    end

endmodule
